// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_image_scaler
FILELIST  := tb.f
OBJDIR    := obj_dir
LOG       := sim.log
VFLAGS    := --timing --top-module $(TOP) -f $(FILELIST)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

$(OBJDIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -Mdir $(OBJDIR)

# run into a log, the log decides pass or fail
sim: $(OBJDIR)/V$(TOP)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== logic/image_scaler.sv ====
module image_scaler #(
  parameter int dst_width = scaler_pkg::dst_width_default // output pixels per line
) (
  input  logic                        pixclk_in,
  input  logic                        rst_n,
  input  logic                        i_de,    // source line active
  input  logic [pixel_pkg::pix_w-1:0] i_pixel, // rgb888
  output logic                        o_de,    // output line active
  output logic [pixel_pkg::pix_w-1:0] o_pixel
);

  logic pair_ready; // line pair stored
  logic pair_page;

  lb_wr_if #(.dst_width(dst_width)) lb_wr ();
  lb_rd_if #(.dst_width(dst_width)) lb_rd ();

  // horizontal 2:1
  pixel_pair_averager #(
    .dst_width(dst_width)
  ) u_pixel_pair_averager (
    .pixclk_in   (pixclk_in),
    .rst_n       (rst_n),
    .i_de        (i_de),
    .i_pixel     (i_pixel),
    .lb_wr       (lb_wr.producer),
    .o_pair_ready(pair_ready),
    .o_pair_page (pair_page)
  );

  // two banks, two pages each
  line_buffer #(
    .dst_width(dst_width)
  ) u_line_buffer (
    .pixclk_in(pixclk_in),
    .lb_wr    (lb_wr.consumer),
    .lb_rd    (lb_rd.memory)
  );

  // vertical 2:1
  row_pair_averager #(
    .dst_width(dst_width)
  ) u_row_pair_averager (
    .pixclk_in   (pixclk_in),
    .rst_n       (rst_n),
    .i_pair_ready(pair_ready),
    .i_pair_page (pair_page),
    .lb_rd       (lb_rd.requester),
    .o_de        (o_de),
    .o_pixel     (o_pixel)
  );

endmodule

// ==== logic/line_buffer.sv ====
module line_buffer #(
  parameter int dst_width = scaler_pkg::dst_width_default
) (
  input  logic      pixclk_in,
  lb_wr_if.consumer lb_wr, // from horizontal stage
  lb_rd_if.memory   lb_rd  // to vertical stage
);

  // one bank per line parity
  localparam int n_banks = 2 ** $bits(scaler_pkg::bank_e);

  // bank x page x column, flat words like a block ram
  logic [pixel_pkg::pix_w-1:0] mem [n_banks][scaler_pkg::n_pages][dst_width];

  // single write port, bank picked by line parity
  always_ff @(posedge pixclk_in) begin
    if (lb_wr.wr_en) begin
      mem[lb_wr.wr_bank][lb_wr.wr_page][lb_wr.wr_addr] <= lb_wr.wr_data.flat;
    end
  end

  // both banks read together
  // registered output, data one cycle after rd_en
  always_ff @(posedge pixclk_in) begin
    if (lb_rd.rd_en) begin
      lb_rd.rd_data_even.flat <= mem[scaler_pkg::bank_even][lb_rd.rd_page][lb_rd.rd_addr];
      lb_rd.rd_data_odd.flat  <= mem[scaler_pkg::bank_odd][lb_rd.rd_page][lb_rd.rd_addr];
    end
  end

endmodule

// ==== logic/line_buffer_if.sv ====
// write side, horizontal stage into the line buffer
interface lb_wr_if #(
  parameter int dst_width = scaler_pkg::dst_width_default
);

  localparam int addr_w = $clog2(dst_width); // column address

  logic              wr_en;   // buffer always accepts
  scaler_pkg::bank_e wr_bank; // line parity
  logic              wr_page; // ping-pong page
  logic [addr_w-1:0] wr_addr; // output column
  pixel_pkg::pixel_u wr_data; // horizontally averaged pixel

  modport producer (
    output wr_en, wr_bank, wr_page, wr_addr, wr_data
  );

  modport consumer (
    input wr_en, wr_bank, wr_page, wr_addr, wr_data
  );

endinterface

// read side, both banks at one page and column
interface lb_rd_if #(
  parameter int dst_width = scaler_pkg::dst_width_default
);

  localparam int addr_w = $clog2(dst_width);

  logic              rd_en;
  logic              rd_page;
  logic [addr_w-1:0] rd_addr;
  pixel_pkg::pixel_u rd_data_even; // valid one cycle after rd_en
  pixel_pkg::pixel_u rd_data_odd;  // same timing

  modport requester (
    output rd_en, rd_page, rd_addr,
    input  rd_data_even, rd_data_odd
  );

  modport memory (
    input  rd_en, rd_page, rd_addr,
    output rd_data_even, rd_data_odd
  );

endinterface

// ==== logic/pixel_pair_averager.sv ====
module pixel_pair_averager #(
  parameter int dst_width = scaler_pkg::dst_width_default
) (
  input  logic              pixclk_in,
  input  logic              rst_n,
  input  logic              i_de,         // high for one source line
  input  pixel_pkg::pixel_u i_pixel,
  lb_wr_if.producer         lb_wr,
  output logic              o_pair_ready, // line pair complete
  output logic              o_pair_page   // page just finished
);

  localparam int addr_w = $clog2(dst_width);
  localparam logic [addr_w-1:0] last_col = addr_w'(dst_width - 1);

  logic              de_q;       // i_de delayed, for falling edge
  logic              have_first; // first pixel of pair held
  pixel_pkg::pixel_u first_pix;
  logic [addr_w-1:0] col;        // next output column
  scaler_pkg::bank_e line_bank;  // parity of current source line
  logic              page;       // page being filled

  // stage 1, averaged pair
  logic              s1_valid;
  pixel_pkg::pixel_u s1_avg;
  logic [addr_w-1:0] s1_addr;
  scaler_pkg::bank_e s1_bank;
  logic              s1_last;    // last column of the line

  logic              pair_done;

  // pairing and line tracking
  always_ff @(posedge pixclk_in) begin
    if (!rst_n) begin
      de_q       <= 1'b0;
      have_first <= 1'b0;
      col        <= '0;
      line_bank  <= scaler_pkg::bank_even;
      s1_valid   <= 1'b0;
    end else begin
      de_q     <= i_de;
      s1_valid <= 1'b0;
      if (i_de) begin
        if (!have_first) begin
          have_first <= 1'b1; // wait for partner
        end else begin
          have_first <= 1'b0;
          s1_valid   <= 1'b1;
          col        <= col + 1'b1;
        end
      end else begin
        have_first <= 1'b0; // stray half pair dropped
        col        <= '0;
        if (de_q) begin
          // end of line, flip parity
          line_bank <= (line_bank == scaler_pkg::bank_even) ?
                       scaler_pkg::bank_odd : scaler_pkg::bank_even;
        end
      end
    end
  end

  // pixel payload
  always_ff @(posedge pixclk_in) begin
    if (i_de && !have_first) begin
      first_pix <= i_pixel;
    end
    if (i_de && have_first) begin
      s1_avg  <= pixel_pkg::avg_pixel(first_pix, i_pixel);
      s1_addr <= col;
      s1_bank <= line_bank;
      s1_last <= (col == last_col);
    end
  end

  // last pair of an odd line closes the line pair
  assign pair_done = s1_valid && s1_last && (s1_bank == scaler_pkg::bank_odd);

  // stage 2, write strobe, page flip and handoff
  always_ff @(posedge pixclk_in) begin
    if (!rst_n) begin
      lb_wr.wr_en  <= 1'b0;
      o_pair_ready <= 1'b0;
      o_pair_page  <= 1'b0;
      page         <= 1'b0;
    end else begin
      lb_wr.wr_en  <= s1_valid;
      o_pair_ready <= pair_done; // same cycle as the last write
      if (pair_done) begin
        o_pair_page <= page; // old page goes to the reader
        page        <= ~page;
      end
    end
  end

  // write payload, page sampled before the flip
  always_ff @(posedge pixclk_in) begin
    if (s1_valid) begin
      lb_wr.wr_bank <= s1_bank;
      lb_wr.wr_page <= page;
      lb_wr.wr_addr <= s1_addr;
      lb_wr.wr_data <= s1_avg;
    end
  end

endmodule

// ==== logic/pixel_pkg.sv ====
package pixel_pkg;

  localparam int chan_w = 8;          // bits per colour channel
  localparam int pix_w  = 3 * chan_w; // rgb888 word

  // channel order matches the incoming stream, red in the top byte
  typedef struct packed {
    logic [chan_w-1:0] r;
    logic [chan_w-1:0] g;
    logic [chan_w-1:0] b;
  } rgb_t;

  // same 24 bits seen two ways
  typedef union packed {
    logic [pix_w-1:0] flat; // as stored in the line buffer
    rgb_t             rgb;  // as the averagers use it
  } pixel_u;

  // per channel floor(a/2) + floor(b/2)
  // halving first keeps the sum inside 8 bits, so no carry leaks into the next channel
  function automatic pixel_u avg_pixel(pixel_u a, pixel_u b);
    pixel_u y;
    y.rgb.r = (a.rgb.r >> 1) + (b.rgb.r >> 1);
    y.rgb.g = (a.rgb.g >> 1) + (b.rgb.g >> 1);
    y.rgb.b = (a.rgb.b >> 1) + (b.rgb.b >> 1);
    return y;
  endfunction

endpackage

// ==== logic/row_pair_averager.sv ====
module row_pair_averager #(
  parameter int dst_width = scaler_pkg::dst_width_default
) (
  input  logic              pixclk_in,
  input  logic              rst_n,
  input  logic              i_pair_ready, // one-cycle pulse
  input  logic              i_pair_page,  // finished page
  lb_rd_if.requester        lb_rd,
  output logic              o_de,
  output pixel_pkg::pixel_u o_pixel
);

  localparam int addr_w = $clog2(dst_width);
  localparam logic [addr_w-1:0] last_addr = addr_w'(dst_width - 1);

  logic rd_valid; // read data present this cycle

  // read sweep over one finished page
  always_ff @(posedge pixclk_in) begin
    if (!rst_n) begin
      lb_rd.rd_en   <= 1'b0;
      lb_rd.rd_page <= 1'b0;
      lb_rd.rd_addr <= '0;
    end else if (i_pair_ready) begin
      lb_rd.rd_en   <= 1'b1;
      lb_rd.rd_page <= i_pair_page; // held for the whole sweep
      lb_rd.rd_addr <= '0;
    end else if (lb_rd.rd_en) begin
      if (lb_rd.rd_addr == last_addr) begin
        lb_rd.rd_en <= 1'b0; // dst_width reads done
      end else begin
        lb_rd.rd_addr <= lb_rd.rd_addr + 1'b1;
      end
    end
  end

  // ram latency marker
  always_ff @(posedge pixclk_in) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= lb_rd.rd_en;
    end
  end

  // vertical average, even row with odd row
  always_ff @(posedge pixclk_in) begin
    if (!rst_n) begin
      o_de    <= 1'b0;
      o_pixel <= '0;
    end else begin
      o_de <= rd_valid;
      if (rd_valid) begin
        o_pixel <= pixel_pkg::avg_pixel(lb_rd.rd_data_even, lb_rd.rd_data_odd);
      end else begin
        o_pixel <= '0; // blank between lines
      end
    end
  end

endmodule

// ==== logic/scaler_pkg.sv ====
package scaler_pkg;

  // output line width when the top level keeps its default
  // source lines are twice this long
  localparam int dst_width_default = 320;

  // ping-pong pages per bank
  // one page fills while the other is read out
  localparam int n_pages = 2;

  // bank select follows source line parity
  // even lines land in bank_even, odd lines in bank_odd
  typedef enum logic {
    bank_even = 1'b0,
    bank_odd  = 1'b1
  } bank_e;

endpackage

// ==== sim/tb_image_scaler.sv ====
module tb_image_scaler;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int dst_w = 8;          // output pixels per line
  localparam int n_src = 2 * dst_w;  // source pixels per line
  localparam int n_stim = 11;
  localparam int drain_limit = 200;  // cycles allowed for the last outputs

  typedef enum logic [1:0] {
    pat_const,   // same colour everywhere
    pat_ramp,    // per channel ramp over columns
    pat_extreme, // 0xff / 0x00 channels alternating by column
    pat_random   // xorshift words
  } pattern_e;

  typedef struct packed {
    pattern_e    pat;
    logic [23:0] base;  // colour or ramp start
    logic [7:0]  gap;   // idle cycles after each line
    logic        extra; // one stray trailing pixel per line
  } stim_t;

  logic        pixclk_in;
  logic        rst_n;
  logic        i_de;
  logic [23:0] i_pixel;
  logic        o_de;
  logic [23:0] o_pixel;

  logic        mon_on;     // monitor armed after first edge
  logic [31:0] rng;        // xorshift state
  logic [23:0] exp_pix;
  logic [23:0] exp_q [$];  // expected output stream
  logic [23:0] line_pix [2][n_src+1];
  int          out_count;  // pixels seen with o_de high
  int          run_len;    // length of current o_de run

  // one line pair per row
  stim_t stim_table [n_stim] = '{
    '{pat_const,   24'h80_40_20, 8'd3, 1'b0}, // even channels pass unchanged
    '{pat_const,   24'hff_01_7f, 8'd2, 1'b0}, // odd channels lose one count
    '{pat_extreme, 24'hff_00_ff, 8'd4, 1'b0}, // no carry across channels
    '{pat_extreme, 24'h00_ff_00, 8'd2, 1'b0},
    '{pat_ramp,    24'h10_20_30, 8'd3, 1'b0}, // column order
    '{pat_ramp,    24'hf0_f8_fc, 8'd5, 1'b0}, // channels wrap
    '{pat_random,  24'h00_00_00, 8'd1, 1'b0}, // back to back pairs with short gaps
    '{pat_random,  24'h00_00_00, 8'd1, 1'b0},
    '{pat_random,  24'h00_00_00, 8'd2, 1'b0},
    '{pat_random,  24'h00_00_00, 8'd2, 1'b1}, // stray half pair dropped
    '{pat_ramp,    24'h01_03_05, 8'd3, 1'b1}
  };

  image_scaler #(
    .dst_width(dst_w)
  ) dut0 (
    .pixclk_in(pixclk_in),
    .rst_n    (rst_n),
    .i_de     (i_de),
    .i_pixel  (i_pixel),
    .o_de     (o_de),
    .o_pixel  (o_pixel)
  );

  initial begin
    pixclk_in = 1'b0;
    forever #2 pixclk_in = ~pixclk_in; // 4 ns period
  end

  // 32 bit xorshift with shifts 13 17 5
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // floor(a/2) + floor(b/2) for one channel
  // never exceeds 254
  function automatic logic [7:0] half_sum(input logic [7:0] a, input logic [7:0] b);
    return {1'b0, a[7:1]} + {1'b0, b[7:1]};
  endfunction

  // channel by channel with b in the low byte
  function automatic logic [23:0] avg_ref(input logic [23:0] a, input logic [23:0] b);
    logic [23:0] y;
    for (int c = 0; c < 3; c++) begin
      y[c*8 +: 8] = half_sum(a[c*8 +: 8], b[c*8 +: 8]);
    end
    return y;
  endfunction

  // deterministic patterns only
  // random words come from the caller
  function automatic logic [23:0] make_pixel(input pattern_e pat, input logic [23:0] base,
                                             input int line, input int col);
    logic [7:0] c8;
    logic [7:0] l8;
    c8 = 8'(col);
    l8 = 8'(line);
    case (pat)
      pat_ramp:    return {base[23:16] + (c8 << 3), base[15:8] + (c8 << 2) + (l8 << 4),
                           base[7:0] + c8};
      pat_extreme: return ((col + line) % 2 == 0) ? base : ~base;
      default:     return base;
    endcase
  endfunction

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
    if (actual !== expected) begin
      $display("error at %0t: %s, got %0h expected %0h", $realtime, msg, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // one source line then its idle gap
  task automatic drive_line(input int line, input int n_pix, input int gap);
    for (int i = 0; i < n_pix; i++) begin
      @(posedge pixclk_in);
      #1;
      i_de    = 1'b1;
      i_pixel = line_pix[line][i];
    end
    @(posedge pixclk_in);
    #1;
    i_de    = 1'b0;
    i_pixel = '0;
    repeat (gap - 1) @(posedge pixclk_in); // gap of 1 is the single low cycle
  endtask

  // build both lines and queue the model output before driving
  task automatic apply_pair(input stim_t s);
    logic [23:0] hrow [2][dst_w];
    int          n_pix;
    n_pix = s.extra ? n_src + 1 : n_src;
    for (int line = 0; line < 2; line++) begin
      for (int col = 0; col < n_pix; col++) begin
        if (s.pat == pat_random) begin
          rng = xorshift(rng);
          line_pix[line][col] = rng[23:0];
        end else begin
          line_pix[line][col] = make_pixel(s.pat, s.base, line, col);
        end
      end
      // horizontal pass ignores a trailing odd pixel
      for (int k = 0; k < dst_w; k++) begin
        hrow[line][k] = avg_ref(line_pix[line][2*k], line_pix[line][2*k+1]);
      end
    end
    for (int k = 0; k < dst_w; k++) begin
      exp_q.push_back(avg_ref(hrow[0][k], hrow[1][k])); // vertical
    end
    drive_line(0, n_pix, int'(s.gap));
    drive_line(1, n_pix, int'(s.gap));
  endtask

  // output monitor samples mid cycle
  always @(negedge pixclk_in) begin
    if (mon_on) begin
      if (o_de) begin
        check_equal(32'(exp_q.size() > 0), 32'd1, "o_de high with no pixel expected");
        exp_pix = exp_q.pop_front();
        check_equal(32'(o_pixel), 32'(exp_pix), $sformatf("o_pixel at output %0d", out_count));
        out_count++;
        run_len++;
      end else begin
        check_equal(32'(o_pixel), 32'd0, "o_pixel not blank while o_de low");
        if (run_len != 0) begin
          check_equal(run_len, dst_w, "o_de run length"); // one unbroken run per pair
          run_len = 0;
        end
      end
    end
  end

  initial begin
    int cycles;
    $timeformat(-9, 1, " ns", 0);
    rst_n     = 1'b0;
    i_de      = 1'b0;
    i_pixel   = '0;
    mon_on    = 1'b0;
    rng       = 32'h071a_658c;
    out_count = 0;
    run_len   = 0;

    @(posedge pixclk_in);
    mon_on = 1'b1;       // reset values checked from here on
    repeat (3) @(posedge pixclk_in);
    #1;
    rst_n = 1'b1;

    for (int e = 0; e < n_stim; e++) begin
      apply_pair(stim_table[e]);
    end

    // let the last pair drain
    cycles = 0;
    while ((exp_q.size() != 0 || o_de || run_len != 0) && cycles < drain_limit) begin
      @(posedge pixclk_in);
      cycles++;
    end

    if (exp_q.size() != 0 || o_de || run_len != 0) begin
      $display("timeout: output stream did not finish, %0d pixels still expected",
               exp_q.size());
      $display("TESTS FAILED");
      $fatal(1, "drain timeout");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

// ==== tb.f ====
logic/pixel_pkg.sv
logic/scaler_pkg.sv
logic/line_buffer_if.sv
logic/pixel_pair_averager.sv
logic/line_buffer.sv
logic/row_pair_averager.sv
logic/image_scaler.sv
sim/tb_image_scaler.sv
